/* hdl/adc_if_consts.svh */
// global constants for the serial SAR ADC receive interface
// include this header wherever the sample width or the frame timing is needed

`ifndef ADC_IF_CONSTS_SVH
`define ADC_IF_CONSTS_SVH

// ---------------------------------------------------------------------------
// converter word
// ---------------------------------------------------------------------------

// number of bits in one conversion result, shifted out MSB first
`define ADC_RESOLUTION 18

// ---------------------------------------------------------------------------
// frame timing, all counts are in ref_clk cycles
// ---------------------------------------------------------------------------

// length of one conversion frame, from one cnv pulse to the next
`define ADC_CONV_PERIOD 24

// cycles the converter needs after cnv before its data can be clocked out
`define ADC_CONV_CYCLES 4

`endif

/* hdl/adc_if_pkg.sv */
// shared types for the serial ADC receive path
// the RTL and the testbench refer to these by scoped names

`include "adc_if_consts.svh"

package adc_if_pkg;

  // ---------------------------------------------------------------------------
  // data types
  // ---------------------------------------------------------------------------

  // one converter sample as it travels from the lanes to the output
  typedef logic [`ADC_RESOLUTION-1:0] sample_t;

  // ---------------------------------------------------------------------------
  // timing types
  // ---------------------------------------------------------------------------

  // position inside a conversion frame, wide enough to reach ADC_CONV_PERIOD
  typedef logic [$clog2(`ADC_CONV_PERIOD)-1:0] conv_count_t;

endpackage

/* hdl/adc_conv_timer.sv */
// conversion timer for the serial ADC interface
// issues one cnv strobe per frame and the registered clock gate window

`timescale 1ns/1ps

`include "adc_if_consts.svh"

module adc_conv_timer #(
  parameter int TWO_LANES = 1
) (
  input  logic ref_clk,
  input  logic rst_n,
  input  logic enable,
  output logic cnv,
  output logic clk_gate
);

  // ---------------------------------------------------------------------------
  // frame geometry
  // ---------------------------------------------------------------------------

  // each gate cycle carries one bit per lane
  localparam int unsigned GATE_LEN = (TWO_LANES != 0) ? (`ADC_RESOLUTION / 2) :
                                                        `ADC_RESOLUTION;

  // last count of a frame, the counter wraps to zero after it
  localparam adc_if_pkg::conv_count_t CNT_LAST =
    adc_if_pkg::conv_count_t'(`ADC_CONV_PERIOD - 1);

  // first count at which the gate register is loaded high
  localparam adc_if_pkg::conv_count_t GATE_OPEN =
    adc_if_pkg::conv_count_t'(`ADC_CONV_CYCLES);

  // first count at which the gate register is loaded low again
  localparam adc_if_pkg::conv_count_t GATE_CLOSE =
    adc_if_pkg::conv_count_t'(`ADC_CONV_CYCLES + GATE_LEN);

  adc_if_pkg::conv_count_t conv_cnt;
  logic                    in_window;

  // ---------------------------------------------------------------------------
  // frame counter
  // ---------------------------------------------------------------------------

  // count zero is the idle point, a frame only starts there when enabled
  // once a frame has left zero it always runs to the wrap, so dropping
  // enable never cuts the data transfer of the current sample
  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      conv_cnt <= '0;
    end else if (conv_cnt == CNT_LAST) begin
      conv_cnt <= '0;
    end else if ((conv_cnt != '0) || enable) begin
      conv_cnt <= conv_cnt + adc_if_pkg::conv_count_t'(1);
    end
  end

  // the convert strobe marks the first cycle of every started frame
  assign cnv = enable && (conv_cnt == '0);

  // ---------------------------------------------------------------------------
  // clock gate window
  // ---------------------------------------------------------------------------

  // counts GATE_OPEN up to GATE_CLOSE-1 are inside the transfer window
  assign in_window = (conv_cnt >= GATE_OPEN) && (conv_cnt < GATE_CLOSE);

  // the gate is registered, so it rises ADC_CONV_CYCLES+1 cycles after cnv
  // and stays high for exactly GATE_LEN cycles
  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_gate <= 1'b0;
    end else begin
      clk_gate <= in_window;
    end
  end

endmodule

/* hdl/adc_lane_deser.sv */
// lane deserializer for the serial ADC interface
// collects one sample from one or two lanes while clk_gate is high

`timescale 1ns/1ps

`include "adc_if_consts.svh"

module adc_lane_deser #(
  parameter int TWO_LANES = 1
) (
  input  logic                ref_clk,
  input  logic                rst_n,
  input  logic                clk_gate,
  input  logic                da,
  input  logic                db,
  output adc_if_pkg::sample_t word,
  output logic                word_done
);

  // ---------------------------------------------------------------------------
  // local signals
  // ---------------------------------------------------------------------------

  // bits arrive MSB first, so older bits move up as new ones come in
  adc_if_pkg::sample_t shift_reg;

  // gate as seen on the previous rising edge
  logic gate_d;

  // the gate was open last cycle and is closed now
  logic gate_fall;

  // ---------------------------------------------------------------------------
  // shift register
  // ---------------------------------------------------------------------------

  // the converter updates the lanes on the falling edge, so on every rising
  // edge with the gate high the lane bits are stable and can be taken
  always_ff @(posedge ref_clk) begin
    if (clk_gate) begin
      if (TWO_LANES != 0) begin
        // da carries the higher bit of each pair, db the lower one
        shift_reg <= {shift_reg[`ADC_RESOLUTION-3:0], da, db};
      end else begin
        // single lane mode, db is left unconnected at the converter
        shift_reg <= {shift_reg[`ADC_RESOLUTION-2:0], da};
      end
    end
  end

  // the shifter only moves while the gate is open, so after the last
  // sampling edge it already holds the complete sample
  assign word = shift_reg;

  // ---------------------------------------------------------------------------
  // end of word detection
  // ---------------------------------------------------------------------------

  assign gate_fall = gate_d && !clk_gate;

  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      gate_d    <= 1'b0;
      word_done <= 1'b0;
    end else begin
      gate_d    <= clk_gate;
      // registered so that word_done lands one cycle after the gate has
      // been seen low, with word stable for the whole pulse
      word_done <= gate_fall;
    end
  end

endmodule

/* hdl/adc_data_format.sv */
// output format stage for the serial ADC interface
// registers each finished word in the selected coding and pulses adc_valid

`timescale 1ns/1ps

`include "adc_if_consts.svh"

module adc_data_format (
  input  logic                ref_clk,
  input  logic                rst_n,
  input  logic                format,
  input  adc_if_pkg::sample_t word,
  input  logic                word_done,
  output logic                adc_valid,
  output adc_if_pkg::sample_t adc_data
);

  // ---------------------------------------------------------------------------
  // code conversion
  // ---------------------------------------------------------------------------

  // the converter delivers offset binary, flipping the MSB gives the
  // two's complement code of the same value
  adc_if_pkg::sample_t word_fmt;

  always_comb begin
    word_fmt = word;
    if (format) begin
      word_fmt[`ADC_RESOLUTION-1] = ~word[`ADC_RESOLUTION-1];
    end
  end

  // ---------------------------------------------------------------------------
  // output register
  // ---------------------------------------------------------------------------

  // format is only looked at while word_done is high, so a change of format
  // between frames takes effect on the next complete word
  // adc_data is held until the next word, there is no back pressure
  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      adc_valid <= 1'b0;
      adc_data  <= '0;
    end else begin
      adc_valid <= word_done;
      if (word_done) begin
        adc_data <= word_fmt;
      end
    end
  end

endmodule

/* hdl/adc_if_top.sv */
// top level of the serial SAR ADC receive interface
// connects the conversion timer, the lane deserializer and the format stage

`timescale 1ns/1ps

module adc_if_top #(
  parameter int TWO_LANES = 1
) (
  input  logic                ref_clk,
  input  logic                rst_n,
  input  logic                enable,
  input  logic                format,
  input  logic                da,
  input  logic                db,
  output logic                cnv,
  output logic                clk_gate,
  output logic                adc_valid,
  output adc_if_pkg::sample_t adc_data
);

  // ---------------------------------------------------------------------------
  // internal wiring
  // ---------------------------------------------------------------------------

  // raw sample from the deserializer, still in the converter's own coding
  adc_if_pkg::sample_t word;

  // one cycle strobe, word is complete while it is high
  logic word_done;

  // ---------------------------------------------------------------------------
  // conversion timer
  // ---------------------------------------------------------------------------

  // clk_gate leaves the chip for the converter and also frames the capture
  adc_conv_timer #(
    .TWO_LANES (TWO_LANES)
  ) u_conv_timer (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .cnv      (cnv),
    .clk_gate (clk_gate)
  );

  // ---------------------------------------------------------------------------
  // lane deserializer
  // ---------------------------------------------------------------------------

  adc_lane_deser #(
    .TWO_LANES (TWO_LANES)
  ) u_lane_deser (
    .ref_clk   (ref_clk),
    .rst_n     (rst_n),
    .clk_gate  (clk_gate),
    .da        (da),
    .db        (db),
    .word      (word),
    .word_done (word_done)
  );

  // ---------------------------------------------------------------------------
  // output format
  // ---------------------------------------------------------------------------

  // adc_valid comes two cycles after the last sampling edge of a frame
  adc_data_format u_data_format (
    .ref_clk   (ref_clk),
    .rst_n     (rst_n),
    .format    (format),
    .word      (word),
    .word_done (word_done),
    .adc_valid (adc_valid),
    .adc_data  (adc_data)
  );

endmodule

/* dv/adc_serial_model.sv */
// behavioral model of the serial SAR converter for the interface testbench
// loads a queued sample on cnv and shifts it out MSB first while clk_gate is high

`timescale 1ns/1ps

`include "adc_if_consts.svh"

module adc_serial_model #(
  parameter int TWO_LANES = 1
) (
  input  logic ref_clk,
  input  logic cnv,
  input  logic clk_gate,
  output logic da,
  output logic db
);

  // samples still to be converted, filled by the testbench
  adc_if_pkg::sample_t sample_q[$];

  // bits of the current sample that have not been shifted out yet
  adc_if_pkg::sample_t out_reg = '0;

  // number of cnv pulses that found the queue empty
  int unsigned underrun_cnt = 0;

  initial begin
    da = 1'b0;
    db = 1'b0;
  end

  task automatic push_sample(input adc_if_pkg::sample_t s);
    sample_q.push_back(s);
  endtask

  // a new sample is taken on the rising edge with cnv high and the lanes
  // change on falling edges so they are stable at the next sampling edge
  always @(ref_clk) begin
    if (ref_clk) begin
      if (cnv) begin
        if (sample_q.size() > 0) begin
          out_reg <= sample_q.pop_front();
        end else begin
          out_reg      <= '0;
          underrun_cnt <= underrun_cnt + 1;
        end
      end
    end else if (clk_gate) begin
      da <= out_reg[`ADC_RESOLUTION-1];
      if (TWO_LANES != 0) begin
        db      <= out_reg[`ADC_RESOLUTION-2];
        out_reg <= out_reg << 2;
      end else begin
        // db is unused in single lane mode
        db      <= 1'b0;
        out_reg <= out_reg << 1;
      end
    end
  end

endmodule

/* dv/adc_if_tb.sv */
// testbench for the serial SAR ADC receive interface
// random samples go through a converter model and come back on adc_data

`timescale 1ns/1ps

`include "adc_if_consts.svh"

module adc_if_tb;

  localparam int TWO_LANES    = 1;
  localparam int RES          = `ADC_RESOLUTION;
  localparam int PERIOD       = `ADC_CONV_PERIOD;
  localparam int GATE_LEN     = (TWO_LANES != 0) ? RES / 2 : RES;
  localparam int TOTAL_FRAMES = 85;
  localparam adc_if_pkg::conv_count_t FRAME_CYCLES = adc_if_pkg::conv_count_t'(PERIOD);
  // every frame at 8 ns per cycle, plus 30 frames for idle gaps and drains
  localparam int WATCHDOG_NS  = (TOTAL_FRAMES + 30) * int'(FRAME_CYCLES) * 8;

  logic                ref_clk;
  logic                rst_n;
  logic                enable;
  logic                format;
  logic                da;
  logic                db;
  logic                cnv;
  logic                clk_gate;
  logic                adc_valid;
  adc_if_pkg::sample_t adc_data;

  // reference copy of the samples handed to the converter model
  adc_if_pkg::sample_t exp_q[$];

  int errors        = 0;
  int tests_run     = 0;
  int tests_failed  = 0;
  int cyc           = 0;
  int cnv_count     = 0;
  int valid_count   = 0;
  int last_cnv_cyc  = 0;
  int gate_cnt      = 0;
  bit have_cnv      = 1'b0;
  bit en_gap        = 1'b1;
  bit valid_pending = 1'b0;
  bit gate_prev     = 1'b0;

  adc_if_top #(.TWO_LANES(TWO_LANES)) dut (
    .ref_clk   (ref_clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .format    (format),
    .da        (da),
    .db        (db),
    .cnv       (cnv),
    .clk_gate  (clk_gate),
    .adc_valid (adc_valid),
    .adc_data  (adc_data)
  );

  adc_serial_model #(.TWO_LANES(TWO_LANES)) converter (
    .ref_clk  (ref_clk),
    .cnv      (cnv),
    .clk_gate (clk_gate),
    .da       (da),
    .db       (db)
  );

  initial ref_clk = 1'b0;
  always #4 ref_clk = ~ref_clk;

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  task automatic note_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // enables conversions for n frames, then drops enable some cycles after the last cnv
  task automatic run_frames(input int n, input int stop_after);
    int target;
    target = cnv_count + n;
    enable = 1'b1;
    while (cnv_count < target) begin
      @(negedge ref_clk);
    end
    repeat (stop_after) @(negedge ref_clk);
    enable = 1'b0;
  endtask

  // waits for the adc_valid of every cnv seen so far
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((valid_count < cnv_count) && (waited < 2 * PERIOD)) begin
      @(negedge ref_clk);
      waited++;
    end
    if (valid_count != cnv_count) begin
      note_error("adc_valid did not arrive after the last cnv");
    end
  endtask

  // ---------------------------------------------------------------------------
  // monitor that reads the outputs on rising edges before they update
  // ---------------------------------------------------------------------------

  always @(posedge ref_clk) begin : monitor
    adc_if_pkg::sample_t exp_data;
    cyc++;
    if (rst_n) begin
      if (!enable) begin
        en_gap = 1'b1;
      end
      if (adc_valid) begin
        valid_count++;
        if (!valid_pending) begin
          note_error("adc_valid came without a cnv before it");
        end
        valid_pending = 1'b0;
        if (exp_q.size() == 0) begin
          note_error("adc_valid came with no sample left in the reference queue");
        end else begin
          // two's complement is the offset binary code with the MSB flipped
          exp_data = exp_q.pop_front();
          if (format) begin
            exp_data[RES-1] = ~exp_data[RES-1];
          end
          check_equal("adc_data", exp_data, adc_data);
        end
      end
      if (clk_gate && !gate_prev) begin
        check_equal("clk_gate open delay", `ADC_CONV_CYCLES + 1, cyc - last_cnv_cyc);
        gate_cnt = 0;
      end
      if (clk_gate) begin
        gate_cnt++;
      end
      if (!clk_gate && gate_prev) begin
        check_equal("clk_gate length", GATE_LEN, gate_cnt);
      end
      gate_prev = clk_gate;
      if (cnv) begin
        if (valid_pending) begin
          note_error("cnv came before the adc_valid of the previous frame");
        end
        // the period is only defined between cnv pulses of one enabled run
        if (have_cnv && !en_gap) begin
          check_equal("cnv period", PERIOD, cyc - last_cnv_cyc);
        end
        cnv_count++;
        valid_pending = 1'b1;
        have_cnv      = 1'b1;
        en_gap        = 1'b0;
        last_cnv_cyc  = cyc;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------

  initial begin : stimulus
    adc_if_pkg::sample_t s;
    int err_before;
    int cnv_before;
    rst_n  = 1'b0;
    enable = 1'b0;
    format = 1'b0;
    void'($urandom(32'h9912_4a93));
    for (int i = 0; i < TOTAL_FRAMES + 4; i++) begin
      s = adc_if_pkg::sample_t'($urandom);
      exp_q.push_back(s);
      converter.push_sample(s);
    end
    // reset covers two rising edges and is released on a falling edge
    repeat (2) @(posedge ref_clk);
    @(negedge ref_clk);
    rst_n = 1'b1;

    err_before = errors;
    repeat (2 * PERIOD) begin
      @(negedge ref_clk);
      if (cnv || clk_gate || adc_valid) begin
        note_error("strobe active while enable is low after reset");
      end
      check_equal("adc_data", 0, adc_data);
    end
    finish_test("idle after reset", err_before);

    err_before = errors;
    run_frames(40, 0);
    wait_drain();
    finish_test("offset binary", err_before);

    // format only changes while the interface is idle
    err_before = errors;
    format = 1'b1;
    run_frames(40, 0);
    wait_drain();
    finish_test("two's complement", err_before);

    err_before = errors;
    format = 1'b0;
    run_frames(4, 0);
    wait_drain();
    finish_test("timer timing", err_before);

    err_before = errors;
    run_frames(1, $urandom_range(PERIOD - 4, 1));
    wait_drain();
    cnv_before = cnv_count;
    repeat (2 * PERIOD) @(negedge ref_clk);
    check_equal("cnv count while disabled", cnv_before, cnv_count);
    check_equal("adc_valid count", cnv_count, valid_count);
    check_equal("model underruns", 0, converter.underrun_cnt);
    finish_test("enable drop", err_before);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+hdl
hdl/adc_if_pkg.sv
hdl/adc_conv_timer.sv
hdl/adc_lane_deser.sv
hdl/adc_data_format.sv
hdl/adc_if_top.sv
dv/adc_serial_model.sv
dv/adc_if_tb.sv

/* Bender.yml */
package:
  name: adc_if

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/adc_if_pkg.sv
      - hdl/adc_conv_timer.sv
      - hdl/adc_lane_deser.sv
      - hdl/adc_data_format.sv
      - hdl/adc_if_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/adc_serial_model.sv
      - dv/adc_if_tb.sv
